// File: compile.f
+incdir+src
src/throttle_pkg.sv
src/cool_down_cnt.sv
src/event_gate.sv
src/cd_config_regs.sv
src/event_merge.sv
src/event_throttle_top.sv
tb/event_throttle_assert.sv
tb/event_throttle_tb.sv

// File: Bender.yml
package:
  name: event_throttle

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/throttle_pkg.sv
      - src/cool_down_cnt.sv
      - src/event_gate.sv
      - src/cd_config_regs.sv
      - src/event_merge.sv
      - src/event_throttle_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/event_throttle_assert.sv
      - tb/event_throttle_tb.sv

// File: tb/event_throttle_tb.sv
// single clock domain; config writes only while every channel is idle, cd values stay below THR_MAX_CD
`timescale 1ns/1ns
`default_nettype none

`include "throttle_macros.svh"

module event_throttle_tb;

    localparam int N = `THR_NUM_CHAN;
    localparam throttle_pkg::cfg_wr_t NO_WR = '0; // idle write port

    logic                      clk;
    logic                      rst_n;
    logic [N-1:0]              evt_in;
    throttle_pkg::cfg_wr_t     cfg_wr;
    logic [`THR_CHAN_W-1:0]    stat_chan;
    throttle_pkg::merged_evt_t evt_out;
    logic [`THR_DROP_W-1:0]    stat_drops;
    logic [`THR_COAL_W-1:0]    coalesce_cnt;
    wire  [N-1:0]              chan_ready;

    throttle_pkg::chan_cfg_t m_cfg [N]; // model copy of the config bank
    logic [N-1:0] m_ready;
    int           m_rem   [N];  // cooldown cycles left
    int           m_drops [N];
    logic [N-1:0] m_pend;       // merger pending bits
    int           m_ptr;        // round-robin pointer
    logic         m_valid;      // model output register
    int           m_chan;
    int           m_coal;

    int          last_acc [N]; // cycle of the last DUT accept
    int          gap_need [N]; // minimum spacing to the next one
    int          cycle;
    logic [31:0] rng;
    string       phase;

    event_throttle_top event_throttle_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .evt_in       (evt_in),
        .cfg_wr       (cfg_wr),
        .stat_chan    (stat_chan),
        .evt_out      (evt_out),
        .stat_drops   (stat_drops),
        .coalesce_cnt (coalesce_cnt),
        .chan_ready   (chan_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at cycle %0d", cycle);
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
            abort_run($sformatf("MISMATCH %s %s: expected %0h, actual %0h",
                                phase, what, exp, act));
    endtask

    // one clock of gates, cooldowns and merger, fed with this cycle's strobes
    task automatic model_step(input logic [N-1:0] evt, output logic [N-1:0] acc);
        logic trig;
        int   cd;
        int   idx;
        logic gv;
        int   gc;
        acc = '0;
        for (int i = 0; i < N; i++)
        begin
            cd     = m_cfg[i].cd;
            trig   = evt[i] & m_cfg[i].enable;
            acc[i] = trig & m_ready[i];     // pass only while idle
            if (evt[i] && !acc[i] && m_drops[i] < 16'hffff)
                m_drops[i]++;
            if (m_ready[i])
            begin
                if (acc[i] && cd != 0)
                begin
                    m_ready[i] = 1'b0;      // window of cd+1 cycles
                    m_rem[i]   = cd;
                end
            end
            else if (trig && m_cfg[i].extend)
                m_rem[i] = cd;              // restart from the last event
            else if (m_rem[i] == 1)
                m_ready[i] = 1'b1;
            else
                m_rem[i]--;
        end
        gv = 1'b0;
        gc = 0;
        for (int k = 0; k < N; k++)
        begin
            idx = (m_ptr + k) % N;
            if (!gv && m_pend[idx])
            begin
                gv = 1'b1;
                gc = idx;
            end
        end
        // accept on a still-waiting channel folds into its pending bit
        for (int i = 0; i < N; i++)
            if (acc[i] && m_pend[i] && !(gv && gc == i) && m_coal < 16'hffff)
                m_coal++;
        if (gv)
        begin
            m_pend[gc] = 1'b0;
            m_ptr      = (gc + 1) % N;
        end
        m_pend  = m_pend | acc;
        m_valid = gv;
        m_chan  = gc;
    endtask

    // drive at edge+1, check registered outputs at the next edge+1
    task automatic step(input logic [N-1:0] evt, input throttle_pkg::cfg_wr_t wr);
        logic [N-1:0] acc;
        evt_in = evt;
        cfg_wr = wr;
        model_step(evt, acc);
        if (wr.we)
            m_cfg[wr.chan] = wr.cfg;
        #2;
        for (int i = 0; i < N; i++)
        begin
            if (event_throttle_top_i.accept[i])
            begin
                assert (cycle - last_acc[i] >= gap_need[i])
                else
                    abort_run($sformatf("channel %0d accepted an event %0d cycles after the last, need %0d",
                                        i, cycle - last_acc[i], gap_need[i]));
                last_acc[i] = cycle;
                gap_need[i] = m_cfg[i].cd + 1;
            end
        end
        @(posedge clk);
        #1;
        cycle++;
        check_val("evt_out.valid", m_valid, evt_out.valid);
        if (m_valid)
            check_val("evt_out.chan", m_chan, evt_out.chan);
        check_val("chan_ready", m_ready, chan_ready);
        check_val("coalesce_cnt", m_coal, coalesce_cnt);
    endtask

    task automatic write_cfg(input int ch, input int cd, input logic ext, input logic en);
        throttle_pkg::cfg_wr_t wr;
        wr.we         = 1'b1;
        wr.chan       = ch;
        wr.cfg.cd     = cd;
        wr.cfg.extend = ext;
        wr.cfg.enable = en;
        step('0, wr);
    endtask

    // strobe probability is prob/256 per masked channel
    task automatic run_events(input logic [N-1:0] mask, input int prob, input int cycles);
        logic [N-1:0] evt;
        for (int n = 0; n < cycles; n++)
        begin
            evt = '0;
            for (int i = 0; i < N; i++)
            begin
                rng = xorshift32(rng);
                if (mask[i] && (rng[7:0] < prob))
                    evt[i] = 1'b1;
            end
            step(evt, NO_WR);
        end
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while (!(chan_ready === '1 && m_ready == '1 && m_pend == '0 && !m_valid))
        begin
            if (n == limit)
                abort_run($sformatf("channels still busy %0d cycles after phase %s", n, phase));
            step('0, NO_WR);
            n++;
        end
    endtask

    task automatic check_drops();
        for (int c = 0; c < N; c++)
        begin
            stat_chan = c;
            step('0, NO_WR); // stat_drops lags stat_chan by one cycle
            check_val($sformatf("stat_drops[%0d]", c), m_drops[c], stat_drops);
        end
    endtask

    initial
    begin
        rst_n     = 1'b0;
        evt_in    = '0;
        cfg_wr    = '0;
        stat_chan = '0;
        rng       = 32'h3605_868b;
        cycle     = 0;
        phase     = "reset";
        m_ready   = '1;
        m_pend    = '0;
        m_ptr     = 0;
        m_valid   = 1'b0;
        m_chan    = 0;
        m_coal    = 0;
        for (int i = 0; i < N; i++)
        begin
            m_cfg[i]    = '0;
            m_rem[i]    = 0;
            m_drops[i]  = 0;
            last_acc[i] = -1000;
            gap_need[i] = 1;
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        phase = "reset_disable"; // everything dropped
        run_events('1, 128, 200);
        wait_idle(16);
        check_drops();

        phase = "single_cd5";
        write_cfg(0, 5, 1'b0, 1'b1);
        run_events(4'b0001, 80, 240);
        wait_idle(32);
        check_drops();

        phase = "extend_cd3"; // dense strobes keep reloading
        write_cfg(1, 3, 1'b1, 1'b1);
        run_events(4'b0010, 200, 120);
        wait_idle(32);
        check_drops();

        phase = "cd_zero";
        write_cfg(2, 0, 1'b0, 1'b1);
        run_events(4'b0100, 128, 150);
        wait_idle(32);
        check_drops();

        phase = "concurrent";
        write_cfg(0, 0, 1'b0, 1'b1);
        write_cfg(1, 1, 1'b0, 1'b1);
        write_cfg(2, 0, 1'b0, 1'b1);
        write_cfg(3, 1, 1'b0, 1'b1);
        run_events('1, 200, 300);
        wait_idle(32);
        check_drops();

        phase = "reconfig"; // new windows from the next accept on
        write_cfg(0, 7, 1'b0, 1'b1);
        write_cfg(1, 2, 1'b1, 1'b1);
        write_cfg(2, 4, 1'b0, 1'b1);
        write_cfg(3, 9, 1'b1, 1'b1);
        run_events('1, 64, 400);
        wait_idle(32);
        check_drops();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/event_throttle_assert.sv
// bound into event_throttle_top only; reaches the merger's pending bits through event_merge_i
`timescale 1ns/1ns
`default_nettype none

`include "throttle_macros.svh"

module event_throttle_assert (
    input wire                            clk,
    input wire                            rst_n,
    input wire [`THR_NUM_CHAN-1:0]        accept,
    input wire [`THR_NUM_CHAN-1:0]        chan_ready,
    input wire [`THR_NUM_CHAN-1:0]        pending,
    input wire throttle_pkg::chan_cfg_t   cfg [`THR_NUM_CHAN],
    input wire throttle_pkg::merged_evt_t evt_out
);

    logic [`THR_NUM_CHAN-1:0] pending_d; // pending bits in the grant cycle
    logic [`THR_NUM_CHAN-1:0] opens;     // accepts that start a cooldown window

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pending_d <= '0;
        else
            pending_d <= pending;
    end

    always_comb
    begin
        for (int i = 0; i < `THR_NUM_CHAN; i++)
            opens[i] = accept[i] & (cfg[i].cd != '0); // cd 0 never leaves ready
    end

    // output names a channel that was waiting
    chan_was_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        evt_out.valid |-> pending_d[evt_out.chan]
    ) else $error("evt_out names channel %0d with no pending event", evt_out.chan);

    // gates stay shut during cooldown
    // ready drops and no second accept right after a window opens
    no_accept_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        opens != '0 |=> ((accept | chan_ready) & $past(opens)) == '0
    ) else $error("accept %b with chan_ready %b right after a window opened",
                  accept, chan_ready);

    quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !evt_out.valid
    ) else $error("evt_out.valid high in the first cycle after reset");

endmodule

bind event_throttle_top event_throttle_assert event_throttle_assert_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .accept     (accept),
    .chan_ready (chan_ready),
    .pending    (event_merge_i.pending_q),
    .cfg        (cfg),
    .evt_out    (evt_out)
);

`default_nettype wire

// File: src/event_throttle_top.sv
// plain strobes in one clock domain; stat_drops lags stat_chan by one cycle and cfg_wr lands one cycle after it is seen
`timescale 1ns/1ns
`default_nettype none

`include "throttle_macros.svh"

module event_throttle_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [`THR_NUM_CHAN-1:0]     evt_in,      // one strobe per channel
    input  wire throttle_pkg::cfg_wr_t   cfg_wr,
    input  wire  [`THR_CHAN_W-1:0]       stat_chan,
    output throttle_pkg::merged_evt_t    evt_out,
    output logic [`THR_DROP_W-1:0]       stat_drops,
    output logic [`THR_COAL_W-1:0]       coalesce_cnt,
    output wire  [`THR_NUM_CHAN-1:0]     chan_ready
);

    throttle_pkg::chan_cfg_t      cfg [`THR_NUM_CHAN]; // per-channel config
    wire [`THR_NUM_CHAN-1:0]      accept;               // gate to merger pulses
    wire [`THR_DROP_W-1:0]        drops [`THR_NUM_CHAN];

    cd_config_regs cd_config_regs_i (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (cfg_wr),
        .cfg   (cfg)
    );

    // one gate and cooldown counter per channel
    for (genvar g = 0; g < `THR_NUM_CHAN; g++)
    begin : gen_gate
        event_gate event_gate_i (
            .clk    (clk),
            .rst_n  (rst_n),
            .cfg    (cfg[g]),
            .evt    (evt_in[g]),
            .accept (accept[g]),
            .ready  (chan_ready[g]),
            .drops  (drops[g])
        );
    end

    event_merge event_merge_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .accept       (accept),
        .evt_out      (evt_out),
        .coalesce_cnt (coalesce_cnt)
    );

    // statistics port
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            stat_drops <= '0;
        else
            stat_drops <= drops[stat_chan]; // registered mux
    end

endmodule

`default_nettype wire

// File: src/event_merge.sv
// no back-pressure; at most one pulse per cycle and an accept on an already pending channel is counted and dropped
`timescale 1ns/1ns
`default_nettype none

`include "throttle_macros.svh"

module event_merge (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [`THR_NUM_CHAN-1:0]    accept,
    output throttle_pkg::merged_evt_t   evt_out,
    output logic [`THR_COAL_W-1:0]      coalesce_cnt
);

    localparam int N  = `THR_NUM_CHAN;
    localparam int CW = `THR_CHAN_W;
    localparam int KW = `THR_COAL_W;

    logic [N-1:0]  pending_q;   // one event waiting per channel
    logic [CW-1:0] ptr_q;       // round-robin start point
    logic          grant_valid;
    logic [CW-1:0] grant_chan;
    logic [N-1:0]  grant_vec;   // one-hot grant
    logic [N-1:0]  coal_vec;    // accepts folded into a pending bit
    logic [CW:0]   coal_num;    // 0 .. N
    logic [KW:0]   coal_sum;    // carry bit flags overflow

    // first pending channel at or after the pointer
    always_comb
    begin : rr_pick
        logic [CW-1:0] idx;
        grant_valid = 1'b0;
        grant_chan  = ptr_q;
        for (int k = 0; k < N; k++)
        begin
            idx = ptr_q + CW'(k); // wraps at N
            if (!grant_valid && pending_q[idx])
            begin
                grant_valid = 1'b1;
                grant_chan  = idx;
            end
        end
    end

    always_comb
    begin
        grant_vec = '0;
        if (grant_valid)
            grant_vec[grant_chan] = 1'b1;
    end

    // a granted bit frees up in the same cycle so a new accept re-arms it
    assign coal_vec = accept & pending_q & ~grant_vec;

    always_comb
    begin
        coal_num = '0;
        for (int i = 0; i < N; i++)
            coal_num = coal_num + (CW+1)'(coal_vec[i]);
    end

    assign coal_sum = {1'b0, coalesce_cnt} + (KW+1)'(coal_num);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending_q    <= '0;
            ptr_q        <= '0;
            evt_out      <= '0;
            coalesce_cnt <= '0;
        end
        else
        begin
            pending_q <= (pending_q & ~grant_vec) | accept;
            if (grant_valid)
                ptr_q <= grant_chan + CW'(1); // next channel after the winner
            evt_out.valid <= grant_valid;       // accept at t shows at t+2
            evt_out.chan  <= grant_chan;
            coalesce_cnt  <= coal_sum[KW] ? '1 : coal_sum[KW-1:0]; // saturate
        end
    end

endmodule

`default_nettype wire

// File: src/cd_config_regs.sv
// write-only bank; a write is visible the cycle after wr.we and there is no read-back path
`timescale 1ns/1ns
`default_nettype none

`include "throttle_macros.svh"

module cd_config_regs (
    input  wire throttle_pkg::cfg_wr_t     wr,
    input  wire                            clk,
    input  wire                            rst_n,
    output throttle_pkg::chan_cfg_t        cfg [`THR_NUM_CHAN]
);

    localparam int N  = `THR_NUM_CHAN;
    localparam int CW = `THR_CHAN_W;

    logic [N-1:0] wr_sel; // one-hot word select

    // decode the target channel
    always_comb
    begin
        wr_sel = '0;
        for (int i = 0; i < N; i++)
        begin
            if (wr.we && (wr.chan == CW'(i)))
            begin
                wr_sel[i] = 1'b1;
            end
        end
    end

    // config words
    // zero means disabled with cd 0 and extend off
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < N; i++)
            begin
                cfg[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < N; i++)
            begin
                if (wr_sel[i])
                begin
                    cfg[i] <= wr.cfg; // whole word replaced
                end
            end
        end
    end

    // a new cd only reaches the counter once it is idle again
    // so writes are meant for quiet channels

endmodule

`default_nettype wire

// File: src/event_gate.sv
// one channel only; evt is a single-cycle strobe and accept is combinational from evt, so drive evt from a register
`timescale 1ns/1ns
`default_nettype none

`include "throttle_macros.svh"

module event_gate (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire throttle_pkg::chan_cfg_t cfg,
    input  wire                       evt,
    output logic                      accept,  // pulse in the event cycle
    output logic                      ready,   // cooldown idle
    output logic [`THR_DROP_W-1:0]    drops    // saturating drop count
);

    logic trig;      // event from an enabled channel
    logic cd_ready;  // counter idle
    logic drop;      // event seen but not passed

    // a disabled channel never starts a cooldown
    assign trig = evt & cfg.enable;

    // pass only when idle
    assign accept = trig & cd_ready;

    // disabled events and events inside the window both count
    assign drop = evt & ~accept;

    assign ready = cd_ready;

    // done and count are not needed at this level
    cool_down_cnt cool_down_cnt_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cd      (cfg.cd),
        .extend  (cfg.extend),   // extend mode reloads on rejected events
        .trigger (trig),
        .done    (),
        .ready   (cd_ready),
        .count   ()
    );

    // drop counter
    // holds at all ones once full
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            drops <= '0;
        end
        else if (drop && (drops != '1))
        begin
            drops <= drops + `THR_DROP_W'(1); // visible next cycle
        end
    end

endmodule

`default_nettype wire

// File: src/cool_down_cnt.sv
// cd is sampled only while ready or at zero; bits of cd above THR_CNT_W are ignored so cd must stay below THR_MAX_CD
`timescale 1ns/1ns
`default_nettype none

`include "throttle_macros.svh"

module cool_down_cnt (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire  [`THR_CD_W-1:0] cd,      // cooldown length minus one
    input  wire                  extend,  // retrigger during cooldown reloads
    input  wire                  trigger,
    output logic                 done,    // last cooldown cycle
    output logic                 ready,
    output logic [`THR_CD_W-1:0] count
);

    localparam int CNT_W = `THR_CNT_W;

    logic [CNT_W-1:0] cd_cnt;  // remaining cooldown cycles
    logic [CNT_W-1:0] cd_lo;   // usable part of cd
    logic             ready_q;
    logic             retrig;  // reload request in extend mode

    assign cd_lo  = cd[CNT_W-1:0];
    assign retrig = extend & trigger;
    assign ready  = ready_q;
    assign count  = {{(`THR_CD_W-CNT_W){1'b0}}, cd_cnt}; // zero-extend

    // cd of zero finishes in the trigger cycle itself
    // otherwise done marks the cycle before ready returns
    assign done = ready_q ? (trigger & (cd_lo == '0))
                          : ((cd_cnt == CNT_W'(1)) & ~retrig);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cd_cnt <= '0;
        end
        else if (ready_q || (cd_cnt == '0))
        begin
            cd_cnt <= cd_lo; // track cd while idle
        end
        else if (retrig)
        begin
            cd_cnt <= cd_lo; // restart the window
        end
        else
        begin
            cd_cnt <= cd_cnt - CNT_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ready_q <= 1'b1; // idle out of reset
        end
        else if (ready_q)
        begin
            ready_q <= ~(trigger & (cd_lo != '0)); // cd 0 never leaves ready
        end
        else
        begin
            ready_q <= (cd_cnt == CNT_W'(1)) & ~retrig;
        end
    end

endmodule

`default_nettype wire

// File: src/throttle_pkg.sv
// shared packed types; field widths come from the macros header and must not be changed here
`default_nettype none

`include "throttle_macros.svh"

package throttle_pkg;

    // one channel's runtime configuration, 18 bits
    typedef struct packed {
        logic [`THR_CD_W-1:0] cd;    // cooldown length minus one
        logic                 extend; // rejected event restarts cooldown
        logic                 enable; // 0 drops everything
    } chan_cfg_t;

    // host write request, 21 bits
    typedef struct packed {
        logic                   we;   // write strobe
        logic [`THR_CHAN_W-1:0] chan; // target channel
        chan_cfg_t              cfg;  // new config word
    } cfg_wr_t;

    // merged output pulse, 3 bits
    typedef struct packed {
        logic                   valid; // one-cycle pulse
        logic [`THR_CHAN_W-1:0] chan;  // source channel
    } merged_evt_t;

endpackage

`default_nettype wire

// File: src/throttle_macros.svh
// compile-time sizes only; THR_NUM_CHAN must equal 2**THR_CHAN_W and cooldowns above THR_MAX_CD are truncated
`ifndef THROTTLE_MACROS_SVH
`define THROTTLE_MACROS_SVH

// number of event channels
`define THR_NUM_CHAN 4

// channel number width, sized so the round-robin pointer wraps on its own
`define THR_CHAN_W 2

// cooldown field in the config word (length minus one)
`define THR_CD_W 16

// longest supported cooldown in cycles
`define THR_MAX_CD 4096

// internal down-counter width derived from the cooldown limit
`define THR_CNT_W ($clog2(`THR_MAX_CD))

// per-channel drop counter width
`define THR_DROP_W 16

// merger coalesce counter width
`define THR_COAL_W 16

`endif
